// File: compile.f
+incdir+.
memory_pkg.sv
update_l2_block.sv
l1dc_line_array.sv
l1dc_check_stage.sv
write_back_buffer.sv
l1dc_sync_top.sv
l1dc_sync_checker.sv
tb_l1dc_sync.sv

// File: tb_l1dc_sync.sv
// ==============================
// L1 D-cache sync testbench
// Fills lines, runs syncs and checks the
// L2 write sequence against a shadow model
// ==============================

`timescale 1ns/1ps
`include "l1dc_settings.svh"

module tb_l1dc_sync;

  localparam int NUM_SETS   = 1 << `L1DC_IDX_LEN;
  localparam int MAX_CYCLES = 4000;

  logic                   clk;
  logic                   rst_n;
  logic                   synch;
  logic                   l2_busy = 1'b0;
  logic                   busy_en;
  logic                   done;
  memory_pkg::l1dc_fill_t fill;
  memory_pkg::l2_wr_t     l2_wr;
  memory_pkg::l2_wr_t     exp_wr;
  memory_pkg::l1dc_line_t shadow [NUM_SETS];
  memory_pkg::l2_wr_t     exp_q [$];

  int err_cnt   = 0;
  int wr_cnt    = 0;
  int done_cnt  = 0;
  int sync_cnt  = 0;
  int cycle_cnt = 0;

  l1dc_sync_top UUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .synch_l1dc_l2c_i  (synch),
    .fill_i            (fill),
    .l2_busy_i         (l2_busy),
    .l2_wr_o           (l2_wr),
    .l2c_update_done_o (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected L2 writes for the next sync, in index order
  // Written lines become clean in the shadow copy
  function automatic void build_expected();
    memory_pkg::l2_wr_t w;
    for (int i = 0; i < NUM_SETS; i++) begin
      if (shadow[i].valid && shadow[i].dirty) begin
        w.valid = 1'b1;
        w.addr  = {shadow[i].tag, i[`L1DC_IDX_LEN-1:0]};
        w.data  = shadow[i].data;
        exp_q.push_back(w);
        shadow[i].dirty = 1'b0;
      end
    end
  endfunction

  function automatic memory_pkg::l1dc_line_t random_line(input bit force_dirty);
    memory_pkg::l1dc_line_t l;
    l.valid = force_dirty || ($urandom % 4 != 0);
    l.dirty = force_dirty || ($urandom % 2 == 1);
    l.tag   = $urandom;
    l.data  = $urandom;
    return l;
  endfunction

  task automatic fill_line(input int idx, input memory_pkg::l1dc_line_t line);
    @(negedge clk);
    fill.valid = 1'b1;
    fill.idx   = idx[`L1DC_IDX_LEN-1:0];
    fill.line  = line;
    shadow[idx] = line;
    @(negedge clk);
    fill.valid = 1'b0;
  endtask

  task automatic run_sync();
    build_expected();
    @(negedge clk);
    synch = 1'b1;
    @(negedge clk);
    synch = 1'b0;
    do @(posedge clk); while (!done);
    sync_cnt++;
    // Let a second done pulse show up if there is one
    repeat (3) @(negedge clk);
    if (done_cnt != sync_cnt) begin
      $display("Sync %0d gave %0d done pulses in total, expected %0d",
               sync_cnt, done_cnt, sync_cnt);
      err_cnt++;
    end
  endtask

  // Random L2 back-pressure
  task automatic drive_l2_busy();
    forever begin
      @(negedge clk);
      l2_busy <= busy_en ? ($urandom % 3 == 0) : 1'b0;
    end
  endtask

  // Compare every L2 strobe with the next expected write
  always @(posedge clk) begin
    if (rst_n) begin
      if (l2_wr.valid) begin
        wr_cnt++;
        if (l2_busy) begin
          $display("L2 write issued while L2 was busy");
          err_cnt++;
        end
        if (exp_q.size() == 0) begin
          $display("Extra L2 write to address %h that no dirty line explains", l2_wr.addr);
          err_cnt++;
        end else begin
          exp_wr = exp_q.pop_front();
          if (l2_wr.addr != exp_wr.addr) begin
            $display("** Error: l2_wr_o.addr = %h, expected %h", l2_wr.addr, exp_wr.addr);
            err_cnt++;
          end
          if (l2_wr.data != exp_wr.data) begin
            $display("** Error: l2_wr_o.data = %h, expected %h", l2_wr.data, exp_wr.data);
            err_cnt++;
          end
        end
      end
      if (done) begin
        done_cnt++;
        if (exp_q.size() != 0) begin
          $display("Done pulse came with %0d L2 writes still missing", exp_q.size());
          err_cnt++;
          exp_q.delete();
        end
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hb46f));
    rst_n    = 1'b0;
    synch    = 1'b0;
    busy_en  = 1'b0;
    fill     = '0;
    for (int i = 0; i < NUM_SETS; i++) shadow[i] = '0;
    fork
      drive_l2_busy();
    join_none
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset, nothing may come out
    repeat (10) @(negedge clk);
    if (done_cnt != 0 || wr_cnt != 0) begin
      $display("Activity on L2 or done before any sync");
      err_cnt++;
    end

    // Empty cache, then a few clean lines
    run_sync();
    for (int i = 0; i < 4; i++) fill_line(i * 3, '{1'b1, 1'b0, 6'(i), 32'(i * 7)});
    run_sync();

    // Random fills, L2 always ready
    for (int i = 0; i < NUM_SETS; i++) fill_line(i, random_line(1'b0));
    run_sync();

    // Random fills under random L2 busy
    for (int i = 0; i < NUM_SETS; i++) fill_line(i, random_line(1'b0));
    busy_en = 1'b1;
    run_sync();

    // Dirty bits already cleared
    run_sync();

    // A few lines dirty again
    fill_line(2, random_line(1'b1));
    fill_line(7, random_line(1'b1));
    fill_line(13, random_line(1'b1));
    fill_line(15, random_line(1'b1));
    run_sync();
    busy_en = 1'b0;
    repeat (5) @(negedge clk);

    $display("Done: %0d errors, %0d L2 writes, %0d syncs, %0d done pulses",
             err_cnt, wr_cnt, sync_cnt, done_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: l1dc_sync_checker.sv
// ==============================
// L1 D-cache sync checker
// Protocol assertions bound into the top
// ==============================

`timescale 1ns/1ps

module l1dc_sync_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic l2_busy_i,
  input logic l2_wr_valid_i,
  input logic done_i,
  input logic fill_valid_i,
  input logic req_valid_i
);

  // L2 takes nothing while busy
  a_no_wr_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_busy_i |-> !l2_wr_valid_i)
    else $error("L2 write strobe raised while L2 busy");

  // Done is a single-cycle pulse
  a_done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("Done output held longer than one cycle");

  // Environment keeps fills away from an active sweep
  a_no_fill_in_sweep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fill_valid_i && req_valid_i))
    else $error("Fill issued while sweep request valid");

endmodule

bind l1dc_sync_top l1dc_sync_checker u_sync_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .l2_busy_i     (l2_busy_i),
  .l2_wr_valid_i (l2_wr_o.valid),
  .done_i        (l2c_update_done_o),
  .fill_valid_i  (fill_i.valid),
  .req_valid_i   (upd_l1dc_req.valid)
);

// File: l1dc_sync_top.sv
// ==============================
// L1 D-cache to L2 sync top
// Sweep, line array, check stage and
// write-back buffer
// ==============================

`timescale 1ns/1ps
`include "l1dc_settings.svh"

module l1dc_sync_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   synch_l1dc_l2c_i,
  input  memory_pkg::l1dc_fill_t fill_i,
  input  logic                   l2_busy_i,
  output memory_pkg::l2_wr_t     l2_wr_o,
  output logic                   l2c_update_done_o
);

  memory_pkg::upd_l1dc_req_t upd_l1dc_req;
  memory_pkg::l1dc_line_t    rd_line;
  memory_pkg::wbb_entry_t    wbb_entry;

  logic                     en_cnt;
  logic                     clr_dirty;
  logic [`L1DC_IDX_LEN-1:0] clr_idx;
  logic                     wbb_push;
  logic                     wbb_full;
  logic                     wbb_empty;

  // Sweep control (d0 requests)
  update_l2_block u_update_l2_block (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .synch_l1dc_l2c_i  (synch_l1dc_l2c_i),
    .en_cnt_i          (en_cnt),
    .wbb_empty_i       (wbb_empty),
    .upd_l1dc_req_o    (upd_l1dc_req),
    .l2c_update_done_o (l2c_update_done_o)
  );

  l1dc_line_array u_line_array (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fill_i         (fill_i),
    .upd_l1dc_req_i (upd_l1dc_req),
    .clr_dirty_i    (clr_dirty),
    .clr_idx_i      (clr_idx),
    .rd_line_o      (rd_line)
  );

  // d1
  l1dc_check_stage u_check_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .upd_l1dc_req_i (upd_l1dc_req),
    .rd_line_i      (rd_line),
    .wbb_full_i     (wbb_full),
    .en_cnt_o       (en_cnt),
    .clr_dirty_o    (clr_dirty),
    .clr_idx_o      (clr_idx),
    .wbb_push_o     (wbb_push),
    .wbb_entry_o    (wbb_entry)
  );

  write_back_buffer u_wbb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_i    (wbb_push),
    .entry_i   (wbb_entry),
    .l2_busy_i (l2_busy_i),
    .full_o    (wbb_full),
    .empty_o   (wbb_empty),
    .l2_wr_o   (l2_wr_o)
  );

endmodule

// File: write_back_buffer.sv
// ==============================
// Write-back buffer
// Small FIFO of dirty lines, drained to
// L2 one per cycle when L2 is not busy
// ==============================

`timescale 1ns/1ps
`include "l1dc_settings.svh"

module write_back_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // From the check stage
  input  logic                   push_i,
  input  memory_pkg::wbb_entry_t entry_i,
  // L2 back-pressure level
  input  logic                   l2_busy_i,
  output logic                   full_o,
  output logic                   empty_o,
  output memory_pkg::l2_wr_t     l2_wr_o
);

  localparam int unsigned DEPTH = `L1DC_WBB_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  memory_pkg::wbb_entry_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));

  // Head leaves in any cycle L2 can take it
  assign pop = !empty_o && !l2_busy_i;

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // Occupancy
  // The check stage never pushes into a full buffer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // L2 strobe straight from the head register
  // Entry pushed in one cycle is visible the next
  assign l2_wr_o.valid = pop;
  assign l2_wr_o.addr  = mem_q[rd_ptr_q].addr;
  assign l2_wr_o.data  = mem_q[rd_ptr_q].data;

endmodule

// File: l1dc_check_stage.sv
// ==============================
// Sync check stage (d1)
// Inspects each swept line and pushes
// dirty ones into the write-back buffer
// ==============================

`timescale 1ns/1ps
`include "l1dc_settings.svh"

module l1dc_check_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  memory_pkg::upd_l1dc_req_t upd_l1dc_req_i,
  // Registered line for the current index
  input  memory_pkg::l1dc_line_t    rd_line_i,
  input  logic                      wbb_full_i,
  // Advance the sweep
  output logic                      en_cnt_o,
  // Dirty clear back to the array
  output logic                      clr_dirty_o,
  output logic [`L1DC_IDX_LEN-1:0]  clr_idx_o,
  // Buffer push
  output logic                      wbb_push_o,
  output memory_pkg::wbb_entry_t    wbb_entry_o
);

  memory_pkg::chk_state_e state_d, state_q;

  // Line holds data not yet in L2
  logic needs_wb;

  assign needs_wb = rd_line_i.valid && rd_line_i.dirty;

  always_comb begin
    state_d    = state_q;
    en_cnt_o   = 1'b0;
    wbb_push_o = 1'b0;
    case (state_q)
      // Array read of the new index in flight
      memory_pkg::chk_read_wait: begin
        if (upd_l1dc_req_i.valid) state_d = memory_pkg::chk_inspect;
      end
      memory_pkg::chk_inspect: begin
        if (!upd_l1dc_req_i.valid) begin
          state_d = memory_pkg::chk_read_wait;
        end else if (!needs_wb) begin
          // Clean or invalid, nothing to write
          en_cnt_o = 1'b1;
          state_d  = memory_pkg::chk_read_wait;
        end else if (!wbb_full_i) begin
          wbb_push_o = 1'b1;
          en_cnt_o   = 1'b1;
          state_d    = memory_pkg::chk_read_wait;
        end
        // Buffer full, hold the same index
      end
      default: state_d = memory_pkg::chk_read_wait;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= memory_pkg::chk_read_wait;
    end else begin
      state_q <= state_d;
    end
  end

  // Clear together with the push
  assign clr_dirty_o = wbb_push_o;
  assign clr_idx_o   = upd_l1dc_req_i.idx;

  // L2 address from stored tag and swept index
  assign wbb_entry_o.addr = {rd_line_i.tag, upd_l1dc_req_i.idx};
  assign wbb_entry_o.data = rd_line_i.data;

endmodule

// File: l1dc_line_array.sv
// ==============================
// L1 D-cache line array
// Line storage with fill writes, a registered
// sweep read and dirty-bit clearing
// ==============================

`timescale 1ns/1ps
`include "l1dc_settings.svh"

module l1dc_line_array (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Environment fill port
  input  memory_pkg::l1dc_fill_t    fill_i,
  // Sweep read request
  input  memory_pkg::upd_l1dc_req_t upd_l1dc_req_i,
  // Dirty clear from the check stage
  input  logic                      clr_dirty_i,
  input  logic [`L1DC_IDX_LEN-1:0]  clr_idx_i,
  output memory_pkg::l1dc_line_t    rd_line_o
);

  localparam int unsigned NUM_SETS = 1 << `L1DC_IDX_LEN;

  memory_pkg::l1dc_line_t lines_q [NUM_SETS];
  memory_pkg::l1dc_line_t rd_line_q;

  // Line storage
  // All sets start invalid and clean
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_SETS; i++) begin
        lines_q[i] <= '0;
      end
    end else begin
      if (fill_i.valid) begin
        lines_q[fill_i.idx] <= fill_i.line;
      end
      // Line was handed to the buffer
      // Fills never overlap a sweep, so no conflict here
      if (clr_dirty_i) begin
        lines_q[clr_idx_i].dirty <= 1'b0;
      end
    end
  end

  // Registered sweep read
  // Line for idx shows up one cycle after the request
  always_ff @(posedge clk_i) begin
    if (upd_l1dc_req_i.valid) begin
      rd_line_q <= lines_q[upd_l1dc_req_i.idx];
    end
  end

  assign rd_line_o = rd_line_q;

endmodule

// File: update_l2_block.sv
// ==============================
// L2 update sweep
// Walks every set index on a sync request,
// waits for the buffer to drain, pulses done
// ==============================

`timescale 1ns/1ps
`include "l1dc_settings.svh"

module update_l2_block #(
  parameter int unsigned IDX_LEN = `L1DC_IDX_LEN
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Sync request from the system
  input  logic                      synch_l1dc_l2c_i,
  // From the check stage
  input  logic                      en_cnt_i,
  // Buffer drained
  input  logic                      wbb_empty_i,
  output memory_pkg::upd_l1dc_req_t upd_l1dc_req_o,
  output logic                      l2c_update_done_o
);

  memory_pkg::upd_state_e state_d, state_q;

  logic [IDX_LEN-1:0] cnt_q;
  // Last set reached
  logic               tc;

  // Index counter
  // Only moves while sweeping, wraps back to 0 after the last set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (en_cnt_i && state_q == memory_pkg::upd_updating) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tc = &cnt_q;

  // Control unit
  always_comb begin
    state_d = state_q;
    case (state_q)
      memory_pkg::upd_idle: begin
        if (synch_l1dc_l2c_i) state_d = memory_pkg::upd_updating;
      end
      memory_pkg::upd_updating: begin
        // Leave once the last set has been handled
        if (tc && en_cnt_i) state_d = memory_pkg::upd_wait_buf;
      end
      memory_pkg::upd_wait_buf: begin
        if (wbb_empty_i) state_d = memory_pkg::upd_done;
      end
      memory_pkg::upd_done: begin
        state_d = memory_pkg::upd_idle;
      end
      default: state_d = memory_pkg::upd_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= memory_pkg::upd_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request held valid for the whole sweep
  assign upd_l1dc_req_o.valid = (state_q == memory_pkg::upd_updating);
  assign upd_l1dc_req_o.idx   = cnt_q;
  // One-cycle done pulse
  assign l2c_update_done_o    = (state_q == memory_pkg::upd_done);

endmodule

// File: memory_pkg.sv
// ==============================
// Memory subsystem types
// Structs and state enums shared by
// the L1 D-cache sync blocks
// ==============================

`include "l1dc_settings.svh"

package memory_pkg;

  // Sweep request towards the line array
  typedef struct packed {
    logic                     valid;
    logic [`L1DC_IDX_LEN-1:0] idx;
  } upd_l1dc_req_t;

  // One direct-mapped line, 40 bits
  typedef struct packed {
    logic                     valid;
    logic                     dirty;
    logic [`L1DC_TAG_LEN-1:0] tag;
    logic [`L1DC_DATA_W-1:0]  data;
  } l1dc_line_t;

  // Environment fill write
  typedef struct packed {
    logic                     valid;
    logic [`L1DC_IDX_LEN-1:0] idx;
    l1dc_line_t               line;
  } l1dc_fill_t;

  // Queued write-back, addr is {tag, idx}
  typedef struct packed {
    logic [`L1DC_ADDR_W-1:0] addr;
    logic [`L1DC_DATA_W-1:0] data;
  } wbb_entry_t;

  // L2 write strobe
  typedef struct packed {
    logic                    valid;
    logic [`L1DC_ADDR_W-1:0] addr;
    logic [`L1DC_DATA_W-1:0] data;
  } l2_wr_t;

  typedef enum logic [1:0] {
    upd_idle, upd_updating, upd_wait_buf, upd_done
  } upd_state_e;

  typedef enum logic {
    chk_read_wait, chk_inspect
  } chk_state_e;

endpackage

// File: l1dc_settings.svh
// ==============================
// L1 D-cache sync settings
// Geometry and buffer sizing for the
// write-back sweep subsystem
// ==============================

`ifndef L1DC_SETTINGS_SVH
`define L1DC_SETTINGS_SVH

// Set index width, 16 sets
`define L1DC_IDX_LEN 4
`define L1DC_TAG_LEN 6
`define L1DC_DATA_W 32
// Write-back buffer entries, power of two
`define L1DC_WBB_DEPTH 4
// L2 line address is tag then index
`define L1DC_ADDR_W (`L1DC_TAG_LEN + `L1DC_IDX_LEN)

`endif
